//--- core_perf_monitor.sv
/*
 * Core memory-traffic performance monitor
 * Observes the instruction and data cache handshakes, counts fetches,
 * loads, stores and read latency, and offers the counters for readback
 */

`timescale 1ns/10ps
`default_nettype none

module core_perf_monitor
    import perf_cfg_pkg::*;
    import perf_ctr_pkg::*;
(
    input  wire             clk,
    input  wire             reset,

    // Instruction cache bus
    input  wire             icache_req_valid,
    input  wire             icache_req_ready,
    input  wire             icache_rsp_valid,
    input  wire             icache_rsp_ready,

    // Data cache bus, one bit per lane
    input  wire lane_mask_t dcache_req_valid,
    input  wire lane_mask_t dcache_req_rw,
    input  wire lane_mask_t dcache_req_ready,
    input  wire lane_mask_t dcache_rsp_valid,
    input  wire lane_mask_t dcache_rsp_ready,

    // Host readback
    input  wire             rd_req,
    input  wire ctr_sel_t   rd_sel,
    output logic            rd_ack,
    output perf_ctr_t       rd_data
);

    logic      ifetch_fire;
    logic      icache_rsp_fire;
    lane_cnt_t dcache_rd_cnt;
    lane_cnt_t dcache_wr_cnt;
    lane_cnt_t dcache_rsp_cnt;

    perf_ctr_t ifetch_latency;
    perf_ctr_t load_latency;

    perf_event_decode u_decode (
        .clk              (clk),
        .reset            (reset),
        .icache_req_valid (icache_req_valid),
        .icache_req_ready (icache_req_ready),
        .icache_rsp_valid (icache_rsp_valid),
        .icache_rsp_ready (icache_rsp_ready),
        .dcache_req_valid (dcache_req_valid),
        .dcache_req_rw    (dcache_req_rw),
        .dcache_req_ready (dcache_req_ready),
        .dcache_rsp_valid (dcache_rsp_valid),
        .dcache_rsp_ready (dcache_rsp_ready),
        .ifetch_fire      (ifetch_fire),
        .icache_rsp_fire  (icache_rsp_fire),
        .dcache_rd_cnt    (dcache_rd_cnt),
        .dcache_wr_cnt    (dcache_wr_cnt),
        .dcache_rsp_cnt   (dcache_rsp_cnt)
    );

    // At most one fetch per cycle on the instruction side
    pending_read_tracker #(
        .cnt_t (logic)
    ) u_icache_trk (
        .clk     (clk),
        .reset   (reset),
        .req_cnt (ifetch_fire),
        .rsp_cnt (icache_rsp_fire),
        .latency (ifetch_latency)
    );

    pending_read_tracker #(
        .cnt_t (lane_cnt_t)
    ) u_dcache_trk (
        .clk     (clk),
        .reset   (reset),
        .req_cnt (dcache_rd_cnt),
        .rsp_cnt (dcache_rsp_cnt),
        .latency (load_latency)
    );

    perf_counter_bank u_bank (
        .clk            (clk),
        .reset          (reset),
        .ifetch_fire    (ifetch_fire),
        .dcache_rd_cnt  (dcache_rd_cnt),
        .dcache_wr_cnt  (dcache_wr_cnt),
        .ifetch_latency (ifetch_latency),
        .load_latency   (load_latency),
        .rd_req         (rd_req),
        .rd_sel         (rd_sel),
        .rd_ack         (rd_ack),
        .rd_data        (rd_data)
    );

endmodule

`default_nettype wire

//--- flist.f
perf_cfg_pkg.sv
perf_ctr_pkg.sv
perf_event_decode.sv
pending_read_tracker.sv
perf_counter_bank.sv
core_perf_monitor.sv
perf_checker.sv
tb_core_perf_monitor.sv

//--- pending_read_tracker.sv
/*
 * Pending read tracker
 * Counts reads still in flight and sums that count every cycle,
 * giving the total read latency in cycles
 */

`timescale 1ns/10ps
`default_nettype none

module pending_read_tracker
    import perf_cfg_pkg::*;
#(
    parameter type cnt_t = logic
) (
    input  wire       clk,
    input  wire       reset,

    input  wire cnt_t req_cnt,
    input  wire cnt_t rsp_cnt,

    output perf_ctr_t latency
);

    perf_ctr_t pending;
    perf_ctr_t pending_next;

    // Requests in, responses out, both from the same cycle
    assign pending_next = pending + perf_ctr_t'(req_cnt) - perf_ctr_t'(rsp_cnt);

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
            latency <= '0;
        end else begin
            pending <= pending_next;
            // Each outstanding read costs one cycle
            latency <= latency + pending;
        end
    end

endmodule

`default_nettype wire

//--- perf_cfg_pkg.sv
/*
 * Memory performance monitor geometry
 * Data-cache lane count, per-cycle lane count width and counter width,
 * with the types built from them
 */

`default_nettype none

package perf_cfg_pkg;

    // Data-cache request lanes watched by the monitor
    localparam int DCACHE_LANES = 4;

    // Holds 0 to DCACHE_LANES
    localparam int LANE_CNT_BITS = $clog2(DCACHE_LANES + 1);

    localparam int PERF_CTR_BITS = 44;

    // One bit per data-cache lane
    typedef logic [DCACHE_LANES-1:0] lane_mask_t;

    // Lanes that fired in a single cycle
    typedef logic [LANE_CNT_BITS-1:0] lane_cnt_t;

    typedef logic [PERF_CTR_BITS-1:0] perf_ctr_t;

endpackage

`default_nettype wire

//--- perf_checker.sv
/*
 * Performance monitor checker
 * Watches the cache handshakes and the readback port of the monitor,
 * derives the expected counters and checks each readback and its timing
 */

`timescale 1ns/10ps
`default_nettype none

module perf_checker
    import perf_cfg_pkg::*;
    import perf_ctr_pkg::*;
(
    input  wire             clk,
    input  wire             reset,

    input  wire             icache_req_valid,
    input  wire             icache_req_ready,
    input  wire             icache_rsp_valid,
    input  wire             icache_rsp_ready,

    input  wire lane_mask_t dcache_req_valid,
    input  wire lane_mask_t dcache_req_rw,
    input  wire lane_mask_t dcache_req_ready,
    input  wire lane_mask_t dcache_rsp_valid,
    input  wire lane_mask_t dcache_rsp_ready,

    input  wire             rd_req,
    input  wire ctr_sel_t   rd_sel,
    input  wire             rd_ack,
    input  wire perf_ctr_t  rd_data,

    output int              value_errors,
    output int              protocol_errors,
    output int              readbacks
);

    longint    cyc;
    longint    n_ifetch;
    longint    n_loads;
    longint    n_stores;
    longint    ic_req_sum;
    longint    ic_rsp_sum;
    longint    ld_req_sum;
    longint    ld_rsp_sum;

    logic      rd_req_prev;
    logic      rd_ack_prev;
    logic      req_open;
    logic      reset_seen;
    longint    req_edge;
    ctr_sel_t  req_sel;
    perf_ctr_t held_data;

    // Counters as the monitor should hold them once traffic has settled
    function automatic perf_ctr_t expected_counter(input ctr_sel_t sel);
        longint value;
        case (sel)
            CTR_IFETCHES:   value = n_ifetch;
            CTR_LOADS:      value = n_loads;
            CTR_STORES:     value = n_stores;
            CTR_IFETCH_LAT: value = ic_rsp_sum - ic_req_sum;
            CTR_LOAD_LAT:   value = ld_rsp_sum - ld_req_sum;
            default:        value = 0;
        endcase
        return perf_ctr_t'(value);
    endfunction

    function automatic string sel_name(input ctr_sel_t sel);
        case (sel)
            CTR_IFETCHES:   return "readback_ifetches";
            CTR_LOADS:      return "readback_loads";
            CTR_STORES:     return "readback_stores";
            CTR_IFETCH_LAT: return "readback_ifetch_lat";
            CTR_LOAD_LAT:   return "readback_load_lat";
            default:        return $sformatf("readback_code_%0d", sel);
        endcase
    endfunction

    initial begin
        value_errors    = 0;
        protocol_errors = 0;
        readbacks       = 0;
        cyc             = 0;
        n_ifetch        = 0;
        n_loads         = 0;
        n_stores        = 0;
        ic_req_sum      = 0;
        ic_rsp_sum      = 0;
        ld_req_sum      = 0;
        ld_rsp_sum      = 0;
        req_open        = 1'b0;
        reset_seen      = 1'b0;
        req_edge        = 0;
        req_sel         = CTR_IFETCHES;
        held_data       = '0;
    end

    always @(posedge clk) begin
        perf_ctr_t expected;
        int        l;
        cyc = cyc + 1;
        if (reset) begin
            if (reset_seen && rd_ack !== 1'b0) begin
                $display("rd_ack is not low during reset at cycle %0d", cyc);
                protocol_errors++;
            end
            reset_seen = 1'b1;
        end else begin
            if (icache_req_valid && icache_req_ready) begin
                n_ifetch++;
                ic_req_sum += cyc;
            end
            if (icache_rsp_valid && icache_rsp_ready) begin
                ic_rsp_sum += cyc;
            end
            for (l = 0; l < DCACHE_LANES; l++) begin
                if (dcache_req_valid[l] && dcache_req_ready[l]) begin
                    if (dcache_req_rw[l]) begin
                        n_stores++;
                    end else begin
                        n_loads++;
                        ld_req_sum += cyc;
                    end
                end
                if (dcache_rsp_valid[l] && dcache_rsp_ready[l]) begin
                    ld_rsp_sum += cyc;
                end
            end

            if (rd_req && !rd_req_prev) begin
                if (req_open || rd_ack) begin
                    $display("rd_req raised at cycle %0d before the last handshake ended", cyc);
                    protocol_errors++;
                end
                req_open = 1'b1;
                req_edge = cyc;
                req_sel  = rd_sel;
            end

            // rd_ack seen high here was raised at the previous edge
            if (rd_ack && !rd_ack_prev) begin
                readbacks++;
                if (!req_open) begin
                    $display("rd_ack rose at cycle %0d without a pending rd_req", cyc);
                    protocol_errors++;
                end else if (cyc - 1 - req_edge != 2) begin
                    $display("rd_ack rose %0d edges after rd_req was sampled, not 2",
                             cyc - 1 - req_edge);
                    protocol_errors++;
                end
                expected = expected_counter(req_sel);
                if (rd_data !== expected) begin
                    $display("FAILED %s: expected 0x%0h, actual 0x%0h",
                             sel_name(req_sel), expected, rd_data);
                    value_errors++;
                end
                held_data = rd_data;
                req_open  = 1'b0;
            end else if (rd_ack && rd_ack_prev && rd_data !== held_data) begin
                $display("rd_data changed at cycle %0d while rd_ack was high", cyc);
                protocol_errors++;
            end

            if (!rd_ack && rd_ack_prev && rd_req_prev) begin
                $display("rd_ack fell at cycle %0d while rd_req was still high", cyc);
                protocol_errors++;
            end
        end
        rd_req_prev = rd_req;
        rd_ack_prev = rd_ack;
    end

endmodule

`default_nettype wire

//--- perf_counter_bank.sv
/*
 * Performance counter bank
 * Accumulates fetch, load and store counts and serves all five
 * counters to the host over a four-phase req/ack readback port
 */

`timescale 1ns/10ps
`default_nettype none

module perf_counter_bank
    import perf_cfg_pkg::*;
    import perf_ctr_pkg::*;
(
    input  wire            clk,
    input  wire            reset,

    input  wire            ifetch_fire,
    input  wire lane_cnt_t dcache_rd_cnt,
    input  wire lane_cnt_t dcache_wr_cnt,
    input  wire perf_ctr_t ifetch_latency,
    input  wire perf_ctr_t load_latency,

    input  wire            rd_req,
    input  wire ctr_sel_t  rd_sel,
    output logic           rd_ack,
    output perf_ctr_t      rd_data
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_LATCH,
        RD_ACK,
        RD_DROP
    } rd_state_t;

    perf_ctr_t ifetches;
    perf_ctr_t loads;
    perf_ctr_t stores;

    perf_ctr_t sel_value;
    rd_state_t rd_state;
    logic      rd_req_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            ifetches <= '0;
            loads    <= '0;
            stores   <= '0;
        end else begin
            ifetches <= ifetches + perf_ctr_t'(ifetch_fire);
            loads    <= loads    + perf_ctr_t'(dcache_rd_cnt);
            stores   <= stores   + perf_ctr_t'(dcache_wr_cnt);
        end
    end

    // Counter select, unused codes give zero
    always_comb begin
        case (rd_sel)
            CTR_IFETCHES:   sel_value = ifetches;
            CTR_LOADS:      sel_value = loads;
            CTR_STORES:     sel_value = stores;
            CTR_IFETCH_LAT: sel_value = ifetch_latency;
            CTR_LOAD_LAT:   sel_value = load_latency;
            default:        sel_value = '0;
        endcase
    end

    // Host request is sampled first, the FSM acts on the sampled copy
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_req_q <= 1'b0;
            rd_state <= RD_IDLE;
            rd_ack   <= 1'b0;
            rd_data  <= '0;
        end else begin
            rd_req_q <= rd_req;
            case (rd_state)
                RD_IDLE: begin
                    if (rd_req_q) begin
                        rd_state <= RD_LATCH;
                    end
                end
                RD_LATCH: begin
                    // Snapshot held until the ack drops
                    rd_data  <= sel_value;
                    rd_ack   <= 1'b1;
                    rd_state <= RD_ACK;
                end
                RD_ACK: begin
                    if (!rd_req_q) begin
                        rd_state <= RD_DROP;
                    end
                end
                RD_DROP: begin
                    rd_ack   <= 1'b0;
                    rd_state <= RD_IDLE;
                end
                default: begin
                    rd_ack   <= 1'b0;
                    rd_state <= RD_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- perf_ctr_pkg.sv
/*
 * Performance counter selector
 * Encoding used by the host on the readback port; codes past the
 * last counter read back as zero
 */

`default_nettype none

package perf_ctr_pkg;

    localparam int CTR_SEL_BITS = 3;

    typedef enum logic [CTR_SEL_BITS-1:0] {
        CTR_IFETCHES   = 3'd0,
        CTR_LOADS      = 3'd1,
        CTR_STORES     = 3'd2,
        CTR_IFETCH_LAT = 3'd3,
        CTR_LOAD_LAT   = 3'd4
    } ctr_sel_t;

endpackage

`default_nettype wire

//--- perf_event_decode.sv
/*
 * Cache bus event decode
 * Classifies instruction and data cache handshakes into fetches,
 * loads, stores and read responses, and registers one cycle's counts
 */

`timescale 1ns/10ps
`default_nettype none

module perf_event_decode
    import perf_cfg_pkg::*;
(
    input  wire             clk,
    input  wire             reset,

    input  wire             icache_req_valid,
    input  wire             icache_req_ready,
    input  wire             icache_rsp_valid,
    input  wire             icache_rsp_ready,

    input  wire lane_mask_t dcache_req_valid,
    input  wire lane_mask_t dcache_req_rw,
    input  wire lane_mask_t dcache_req_ready,
    input  wire lane_mask_t dcache_rsp_valid,
    input  wire lane_mask_t dcache_rsp_ready,

    output logic            ifetch_fire,
    output logic            icache_rsp_fire,
    output lane_cnt_t       dcache_rd_cnt,
    output lane_cnt_t       dcache_wr_cnt,
    output lane_cnt_t       dcache_rsp_cnt
);

    lane_mask_t rd_fire;
    lane_mask_t wr_fire;
    lane_mask_t rsp_fire;

    lane_cnt_t  rd_sum;
    lane_cnt_t  wr_sum;
    lane_cnt_t  rsp_sum;

    // Per-lane fire masks
    assign rd_fire  = dcache_req_valid & dcache_req_ready & ~dcache_req_rw;
    assign wr_fire  = dcache_req_valid & dcache_req_ready & dcache_req_rw;
    assign rsp_fire = dcache_rsp_valid & dcache_rsp_ready;

    // Population counts over the lanes
    always_comb begin
        rd_sum  = '0;
        wr_sum  = '0;
        rsp_sum = '0;
        for (int i = 0; i < DCACHE_LANES; i++) begin
            rd_sum  = rd_sum  + lane_cnt_t'(rd_fire[i]);
            wr_sum  = wr_sum  + lane_cnt_t'(wr_fire[i]);
            rsp_sum = rsp_sum + lane_cnt_t'(rsp_fire[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ifetch_fire     <= 1'b0;
            icache_rsp_fire <= 1'b0;
            dcache_rd_cnt   <= '0;
            dcache_wr_cnt   <= '0;
            dcache_rsp_cnt  <= '0;
        end else begin
            ifetch_fire     <= icache_req_valid & icache_req_ready;
            icache_rsp_fire <= icache_rsp_valid & icache_rsp_ready;
            dcache_rd_cnt   <= rd_sum;
            dcache_wr_cnt   <= wr_sum;
            dcache_rsp_cnt  <= rsp_sum;
        end
    end

endmodule

`default_nettype wire

//--- tb_core_perf_monitor.sv
/*
 * Testbench for the core performance monitor
 * Models both caches with random traffic and delayed read responses,
 * then reads the counters back over the four-phase port
 */

`timescale 1ns/10ps
`default_nettype none

module tb_core_perf_monitor
    import perf_cfg_pkg::*;
    import perf_ctr_pkg::*;
();

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 5;
    localparam int IC_CYCLES      = 200;
    localparam int DC_CYCLES      = 200;
    localparam int MIX_CYCLES     = 150;
    localparam int MAX_HOLD       = 8;
    localparam int READBACKS      = 19;
    localparam int READ_CYCLES    = 4 + MAX_HOLD + 4;
    localparam int TRAFFIC_CYCLES = IC_CYCLES + DC_CYCLES + MIX_CYCLES;
    // Draining a phase may take as long as the phase itself
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 2 * TRAFFIC_CYCLES
                                   + READBACKS * READ_CYCLES + 200;
    localparam int SLOTS          = 16;

    logic       clk;
    logic       reset;
    logic       icache_req_valid;
    logic       icache_req_ready;
    logic       icache_rsp_valid;
    logic       icache_rsp_ready;
    lane_mask_t dcache_req_valid;
    lane_mask_t dcache_req_rw;
    lane_mask_t dcache_req_ready;
    lane_mask_t dcache_rsp_valid;
    lane_mask_t dcache_rsp_ready;
    logic       rd_req;
    ctr_sel_t   rd_sel;
    logic       rd_ack;
    perf_ctr_t  rd_data;

    int value_errors;
    int protocol_errors;
    int readbacks;

    int seed;
    int tcyc;
    // Response delay lines, one slot per cycle
    int ic_sched [SLOTS];
    int dc_sched [DCACHE_LANES*SLOTS];
    int ic_avail;
    int dc_avail [DCACHE_LANES];
    int ic_outstanding;
    int dc_outstanding;

    core_perf_monitor dut0 (
        .clk(clk), .reset(reset),
        .icache_req_valid(icache_req_valid), .icache_req_ready(icache_req_ready),
        .icache_rsp_valid(icache_rsp_valid), .icache_rsp_ready(icache_rsp_ready),
        .dcache_req_valid(dcache_req_valid), .dcache_req_rw(dcache_req_rw),
        .dcache_req_ready(dcache_req_ready), .dcache_rsp_valid(dcache_rsp_valid),
        .dcache_rsp_ready(dcache_rsp_ready),
        .rd_req(rd_req), .rd_sel(rd_sel), .rd_ack(rd_ack), .rd_data(rd_data)
    );

    perf_checker u_checker (
        .clk(clk), .reset(reset),
        .icache_req_valid(icache_req_valid), .icache_req_ready(icache_req_ready),
        .icache_rsp_valid(icache_rsp_valid), .icache_rsp_ready(icache_rsp_ready),
        .dcache_req_valid(dcache_req_valid), .dcache_req_rw(dcache_req_rw),
        .dcache_req_ready(dcache_req_ready), .dcache_rsp_valid(dcache_rsp_valid),
        .dcache_rsp_ready(dcache_rsp_ready),
        .rd_req(rd_req), .rd_sel(rd_sel), .rd_ack(rd_ack), .rd_data(rd_data),
        .value_errors(value_errors), .protocol_errors(protocol_errors),
        .readbacks(readbacks)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic bit chance(input int percent);
        int r;
        r = $unsigned($random(seed)) % 100;
        return r < percent;
    endfunction

    // One cycle of cache traffic, driven on the falling edge
    task automatic drive_cycle(input bit ic_traffic, input bit dc_traffic);
        int slot;
        int d;
        int l;
        @(negedge clk);
        tcyc = tcyc + 1;
        slot = tcyc % SLOTS;
        ic_avail = ic_avail + ic_sched[slot];
        ic_sched[slot] = 0;
        icache_req_valid = ic_traffic && chance(60);
        icache_req_ready = chance(70);
        if (icache_req_valid && icache_req_ready) begin
            d = 1 + $unsigned($random(seed)) % 8;
            ic_sched[(tcyc + d) % SLOTS]++;
            ic_outstanding++;
        end
        icache_rsp_valid = (ic_avail > 0);
        icache_rsp_ready = ic_traffic ? chance(70) : 1'b1;
        if (icache_rsp_valid && icache_rsp_ready) begin
            ic_avail--;
            ic_outstanding--;
        end
        for (l = 0; l < DCACHE_LANES; l++) begin
            dc_avail[l] = dc_avail[l] + dc_sched[l*SLOTS + slot];
            dc_sched[l*SLOTS + slot] = 0;
            dcache_req_valid[l] = dc_traffic && chance(50);
            dcache_req_rw[l]    = chance(40);
            dcache_req_ready[l] = chance(75);
            // Only loads are answered
            if (dcache_req_valid[l] && dcache_req_ready[l] && !dcache_req_rw[l]) begin
                d = 1 + $unsigned($random(seed)) % 8;
                dc_sched[l*SLOTS + (tcyc + d) % SLOTS]++;
                dc_outstanding++;
            end
            dcache_rsp_valid[l] = (dc_avail[l] > 0);
            dcache_rsp_ready[l] = dc_traffic ? chance(70) : 1'b1;
            if (dcache_rsp_valid[l] && dcache_rsp_ready[l]) begin
                dc_avail[l]--;
                dc_outstanding--;
            end
        end
    endtask

    task automatic run_traffic(input int cycles, input bit ic_on, input bit dc_on);
        repeat (cycles) drive_cycle(ic_on, dc_on);
        while (ic_outstanding > 0 || dc_outstanding > 0) begin
            drive_cycle(1'b0, 1'b0);
        end
        repeat (3) drive_cycle(1'b0, 1'b0);
    endtask

    task automatic read_counter(input ctr_sel_t sel);
        int hold;
        hold = $unsigned($random(seed)) % (MAX_HOLD + 1);
        @(negedge clk);
        rd_sel = sel;
        rd_req = 1'b1;
        while (rd_ack !== 1'b1) @(negedge clk);
        repeat (hold) @(negedge clk);
        rd_req = 1'b0;
        while (rd_ack !== 1'b0) @(negedge clk);
    endtask

    task automatic read_all;
        read_counter(CTR_IFETCHES);
        read_counter(CTR_LOADS);
        read_counter(CTR_STORES);
        read_counter(CTR_IFETCH_LAT);
        read_counter(CTR_LOAD_LAT);
    endtask

    initial begin
        int i;
        seed = 78;
        clk = 1'b0;
        reset = 1'b1;
        icache_req_valid = 1'b0;
        icache_req_ready = 1'b0;
        icache_rsp_valid = 1'b0;
        icache_rsp_ready = 1'b0;
        dcache_req_valid = '0;
        dcache_req_rw    = '0;
        dcache_req_ready = '0;
        dcache_rsp_valid = '0;
        dcache_rsp_ready = '0;
        rd_req = 1'b0;
        rd_sel = CTR_IFETCHES;
        tcyc = 0;
        ic_avail = 0;
        ic_outstanding = 0;
        dc_outstanding = 0;
        for (i = 0; i < SLOTS; i++) ic_sched[i] = 0;
        for (i = 0; i < DCACHE_LANES*SLOTS; i++) dc_sched[i] = 0;
        for (i = 0; i < DCACHE_LANES; i++) dc_avail[i] = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Idle monitor, unused code 7 included
        read_all();
        read_counter(ctr_sel_t'(3'd7));

        run_traffic(IC_CYCLES, 1'b1, 1'b0);
        read_counter(CTR_IFETCHES);
        read_counter(CTR_IFETCH_LAT);

        run_traffic(DC_CYCLES, 1'b0, 1'b1);
        read_counter(CTR_LOADS);
        read_counter(CTR_STORES);
        read_counter(CTR_LOAD_LAT);

        run_traffic(MIX_CYCLES, 1'b1, 1'b1);
        read_all();

        // Unused codes while every counter is non-zero
        read_counter(ctr_sel_t'(3'd5));
        read_counter(ctr_sel_t'(3'd6));
        read_counter(ctr_sel_t'(3'd7));

        repeat (3) @(negedge clk);
        if (readbacks != READBACKS) begin
            $display("%0d readbacks were acknowledged, %0d were issued",
                     readbacks, READBACKS);
        end
        $display("Readbacks: %0d, value errors: %0d, protocol errors: %0d",
                 readbacks, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0 && readbacks == READBACKS) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, a drain or readback never finished",
                 WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire
